// File: build.f
source/ifu_core_pkg.sv
source/ifu_fetch_pkg.sv
source/ifu_fetch_ctrl.sv
source/ifu_hold_buf.sv
source/ifu_top.sv
verif/tb_ifu.sv

// File: run.sh
#!/bin/sh
# compile and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

rm -rf "$obj"
rm -f "$log"

verilator --binary --timing --assert \
  --timescale 1ns/1ns \
  --top-module tb_ifu \
  --Mdir "$obj" \
  -f build.f \
  -o tb_ifu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit 1
fi

"./$obj/tb_ifu_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench verdict lives in the log
if grep -q "sim failed" "$log"; then
  echo "testbench reported failure, see $log"
  exit 1
fi

echo "no failure reported in $log"
exit 0

// File: verif/tb_ifu.sv
`timescale 1ns/1ns

module tb_ifu;

  localparam ifu_core_pkg::addr_t reset_pc = ifu_core_pkg::default_reset_pc;
  localparam int lat_n = 256;

  logic                clk;
  logic                rst;
  logic                i_alu_vld;
  logic                i_alu_freeze;
  logic                i_alu_br_miss;
  logic                i_alu_trap;
  ifu_core_pkg::addr_t i_alu_pc_next;
  logic                i_idu_freeze;
  logic                o_ifu_vld;
  ifu_core_pkg::inst_t o_ifu_inst;
  ifu_core_pkg::addr_t o_ifu_inst_pc;
  logic                o_instbus_req;
  ifu_core_pkg::addr_t o_instbus_addr;
  logic                i_instbus_ack;
  ifu_core_pkg::inst_t i_instbus_data;

  // bus model state
  int                  lat_tab [lat_n];
  int                  lat_idx = 0;
  logic                slow_bus = 1'b0;
  logic                bus_pend;
  int                  bus_wait;
  ifu_core_pkg::addr_t bus_addr;

  // reference model and checker state
  ifu_core_pkg::addr_t exp_q [$];
  ifu_core_pkg::addr_t exp_pc;
  logic                redirect_now;
  logic                idu_freeze_prev = 1'b0;
  logic                alu_freeze_prev = 1'b0;
  logic                rst_prev = 1'b0;
  int                  rst_edges = 0;
  int                  errs_now;
  int                  delivered = 0;
  int                  err_count = 0;
  int                  test_idx = 0;

  // bookkeeping of the main sequence
  int                  cur_test;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  int                  wait_errs = 0;
  int                  err_start;
  int                  wait_err_start;
  int                  deliv_start;

  ifu_top #(
    .reset_pc (reset_pc)
  ) ifu_top_i (
    .clk            (clk),
    .rst            (rst),
    .i_alu_vld      (i_alu_vld),
    .i_alu_freeze   (i_alu_freeze),
    .i_alu_br_miss  (i_alu_br_miss),
    .i_alu_trap     (i_alu_trap),
    .i_alu_pc_next  (i_alu_pc_next),
    .i_idu_freeze   (i_idu_freeze),
    .o_ifu_vld      (o_ifu_vld),
    .o_ifu_inst     (o_ifu_inst),
    .o_ifu_inst_pc  (o_ifu_inst_pc),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data)
  );

  // odd multiplier gives every address its own word
  function automatic ifu_core_pkg::inst_t mem_word(input ifu_core_pkg::addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  function automatic ifu_core_pkg::addr_t next_fetch_pc(input ifu_core_pkg::addr_t pc);
    return pc + ifu_core_pkg::inst_bytes;
  endfunction

  function automatic string test_label(input int idx);
    case (idx)
      0: return "reset";
      1: return "sequential";
      2: return "decode_backpressure";
      3: return "execute_freeze";
      4: return "branch_miss";
      5: return "trap_in_flight";
      default: return "unknown";
    endcase
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // instruction bus model answering after 1 to 4 cycles
  initial begin
    i_instbus_ack  <= 1'b0;
    i_instbus_data <= '0;
    bus_pend = 1'b0;
    bus_wait = 0;
    bus_addr = '0;
    forever begin
      @(posedge clk);
      if (rst) begin
        bus_pend = 1'b0;
        i_instbus_ack <= 1'b0;
      end else begin
        if (o_instbus_req) begin
          bus_pend = 1'b1;
          bus_addr = o_instbus_addr;
          bus_wait = slow_bus ? 3 : lat_tab[lat_idx];
          lat_idx  = (lat_idx + 1) % lat_n;
        end
        if (bus_pend && bus_wait == 0) begin
          i_instbus_ack  <= 1'b1;
          i_instbus_data <= mem_word(bus_addr);
          bus_pend = 1'b0;
        end else begin
          i_instbus_ack <= 1'b0;
          if (bus_pend) begin
            bus_wait = bus_wait - 1;
          end
        end
      end
    end
  end

  // checker sampling the cycle that just ended
  always @(posedge clk) begin
    errs_now = 0;
    redirect_now = i_alu_vld && (i_alu_br_miss || i_alu_trap);

    // outputs are only known once one reset edge has passed
    if (rst_edges > 0 && (rst || rst_prev)) begin
      assert (!o_instbus_req && !o_ifu_vld) else begin
        $display("%s: bus request or decode valid high during or right after reset",
                 test_label(test_idx));
        errs_now++;
      end
    end

    if (rst) begin
      rst_edges = rst_edges + 1;
      exp_q.delete();
      exp_q.push_back(reset_pc);
    end else begin
      if (o_ifu_vld) begin
        exp_pc = exp_q.pop_front();
        exp_q.push_back(next_fetch_pc(exp_pc));
        assert (o_ifu_inst_pc == exp_pc) else begin
          $display("Mismatch %s pc: expected %h, actual %h",
                   test_label(test_idx), exp_pc, o_ifu_inst_pc);
          errs_now++;
        end
        assert (o_ifu_inst == mem_word(exp_pc)) else begin
          $display("Mismatch %s inst at %h: expected %h, actual %h",
                   test_label(test_idx), exp_pc, mem_word(exp_pc), o_ifu_inst);
          errs_now++;
        end
        assert (!idu_freeze_prev) else begin
          $display("%s: decode valid pulsed in the cycle after a decode freeze",
                   test_label(test_idx));
          errs_now++;
        end
        delivered <= delivered + 1;
      end
      assert (!(o_instbus_req && alu_freeze_prev)) else begin
        $display("%s: bus request issued in the cycle after an execute freeze",
                 test_label(test_idx));
        errs_now++;
      end
      // new stream from the next cycle on
      if (redirect_now) begin
        exp_q.delete();
        exp_q.push_back(i_alu_pc_next);
      end
    end

    idu_freeze_prev = i_idu_freeze;
    alu_freeze_prev = i_alu_vld && i_alu_freeze && !redirect_now;
    rst_prev = rst;
    if (errs_now > 0) begin
      err_count <= err_count + errs_now;
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic begin_test(input int idx);
    test_idx <= idx;
    cur_test = idx;
    err_start = err_count;
    wait_err_start = wait_errs;
    deliv_start = delivered;
  endtask

  task automatic end_test();
    int errs;
    int ndel;
    idle_cycles(2);
    // counters settle after the last checker edge
    @(negedge clk);
    errs = (err_count - err_start) + (wait_errs - wait_err_start);
    ndel = delivered - deliv_start;
    tests_run++;
    if (errs > 0) begin
      tests_failed++;
    end
    $display("test %s: %s, delivered %0d, errors %0d",
             test_label(cur_test), (errs == 0) ? "ok" : "FAILED", ndel, errs);
  endtask

  task automatic wait_deliveries(input int n, input int limit, input bit rand_freeze);
    int target;
    int cycles;
    target = delivered + n;
    cycles = 0;
    while (delivered < target && cycles < limit) begin
      @(posedge clk);
      if (rand_freeze) begin
        i_idu_freeze <= ($urandom_range(1, 0) == 1);
      end
      cycles++;
    end
    if (rand_freeze) begin
      i_idu_freeze <= 1'b0;
    end
    if (delivered < target) begin
      $display("%s: timed out after %0d cycles waiting for %0d deliveries",
               test_label(cur_test), limit, n);
      wait_errs++;
    end
  endtask

  task automatic wait_bus_req(input int limit);
    int  cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < limit) begin
      @(posedge clk);
      seen = o_instbus_req;
      cycles++;
    end
    if (!seen) begin
      $display("%s: no bus request within %0d cycles", test_label(cur_test), limit);
      wait_errs++;
    end
  endtask

  // one-cycle branch miss or trap
  task automatic redirect_to(input ifu_core_pkg::addr_t target, input bit is_trap);
    i_alu_vld     <= 1'b1;
    i_alu_br_miss <= !is_trap;
    i_alu_trap    <= is_trap;
    i_alu_pc_next <= target;
    @(posedge clk);
    i_alu_vld     <= 1'b0;
    i_alu_br_miss <= 1'b0;
    i_alu_trap    <= 1'b0;
  endtask

  task automatic hold_alu_freeze(input int n);
    i_alu_vld    <= 1'b1;
    i_alu_freeze <= 1'b1;
    idle_cycles(n);
    i_alu_vld    <= 1'b0;
    i_alu_freeze <= 1'b0;
  endtask

  initial begin
    void'($urandom(73195));
    for (int i = 0; i < lat_n; i++) begin
      lat_tab[i] = $urandom_range(3, 0);
    end
    rst           <= 1'b1;
    i_alu_vld     <= 1'b0;
    i_alu_freeze  <= 1'b0;
    i_alu_br_miss <= 1'b0;
    i_alu_trap    <= 1'b0;
    i_alu_pc_next <= '0;
    i_idu_freeze  <= 1'b0;

    begin_test(0);
    idle_cycles(8);
    rst <= 1'b0;
    end_test();

    begin_test(1);
    wait_deliveries(12, 300, 1'b0);
    end_test();

    begin_test(2);
    wait_deliveries(16, 800, 1'b1);
    end_test();

    begin_test(3);
    wait_deliveries(2, 100, 1'b0);
    hold_alu_freeze(10);
    wait_deliveries(6, 200, 1'b0);
    end_test();

    // held entry gets flushed by the redirect
    begin_test(4);
    wait_deliveries(3, 100, 1'b0);
    i_idu_freeze <= 1'b1;
    idle_cycles(6);
    redirect_to(32'h0000_1000, 1'b0);
    i_idu_freeze <= 1'b0;
    wait_deliveries(8, 200, 1'b0);
    end_test();

    // slow bus so the trap lands while the response is outstanding
    begin_test(5);
    slow_bus <= 1'b1;
    wait_bus_req(50);
    redirect_to(32'h0000_2040, 1'b1);
    wait_deliveries(6, 200, 1'b0);
    slow_bus <= 1'b0;
    end_test();

    $display("%0d tests, %0d failed, %0d errors",
             tests_run, tests_failed, err_count + wait_errs);
    if (tests_failed == 0 && err_count + wait_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: source/ifu_top.sv
`timescale 1ns/1ns

module ifu_top #(
  parameter ifu_core_pkg::addr_t reset_pc = ifu_core_pkg::default_reset_pc
) (
  input  logic                 clk,
  input  logic                 rst,

  // execute stage
  input  logic                 i_alu_vld,
  input  logic                 i_alu_freeze,
  input  logic                 i_alu_br_miss,
  input  logic                 i_alu_trap,
  input  ifu_core_pkg::addr_t  i_alu_pc_next,

  // decode stage
  input  logic                 i_idu_freeze,
  output logic                 o_ifu_vld,
  output ifu_core_pkg::inst_t  o_ifu_inst,
  output ifu_core_pkg::addr_t  o_ifu_inst_pc,

  // instruction bus
  output logic                 o_instbus_req,
  output ifu_core_pkg::addr_t  o_instbus_addr,
  input  logic                 i_instbus_ack,
  input  ifu_core_pkg::inst_t  i_instbus_data
);

  logic                        push;
  ifu_fetch_pkg::fetch_entry_t push_entry;
  logic                        flush;
  logic                        full;

  ifu_fetch_ctrl #(
    .reset_pc (reset_pc)
  ) ifu_fetch_ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .i_alu_vld      (i_alu_vld),
    .i_alu_freeze   (i_alu_freeze),
    .i_alu_br_miss  (i_alu_br_miss),
    .i_alu_trap     (i_alu_trap),
    .i_alu_pc_next  (i_alu_pc_next),
    .o_instbus_req  (o_instbus_req),
    .o_instbus_addr (o_instbus_addr),
    .i_instbus_ack  (i_instbus_ack),
    .i_instbus_data (i_instbus_data),
    .i_full         (full),
    .o_push         (push),
    .o_push_entry   (push_entry),
    .o_flush        (flush)
  );

  // one-entry buffer toward decode
  ifu_hold_buf ifu_hold_buf_i (
    .clk           (clk),
    .rst           (rst),
    .i_push        (push),
    .i_push_entry  (push_entry),
    .i_flush       (flush),
    .o_full        (full),
    .i_idu_freeze  (i_idu_freeze),
    .o_ifu_vld     (o_ifu_vld),
    .o_ifu_inst    (o_ifu_inst),
    .o_ifu_inst_pc (o_ifu_inst_pc)
  );

endmodule

// File: source/ifu_hold_buf.sv
`timescale 1ns/1ns

module ifu_hold_buf (
  input  logic                         clk,
  input  logic                         rst,

  // from fetch control
  input  logic                         i_push,
  input  ifu_fetch_pkg::fetch_entry_t  i_push_entry,
  input  logic                         i_flush,
  output logic                         o_full,

  // decode stage
  input  logic                         i_idu_freeze,
  output logic                         o_ifu_vld,
  output ifu_core_pkg::inst_t          o_ifu_inst,
  output ifu_core_pkg::addr_t          o_ifu_inst_pc
);

  ifu_fetch_pkg::fetch_entry_t entry;
  logic                        full;
  logic                        vld;
  ifu_core_pkg::inst_t         out_inst;
  ifu_core_pkg::addr_t         out_pc;
  logic                        release_entry;

  // entry leaves when decode is free and the stream is still valid
  assign release_entry = full & ~i_idu_freeze & ~i_flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
      vld  <= 1'b0;
    end else if (i_flush) begin
      // old stream, drop held entry and pending pulse
      full <= 1'b0;
      vld  <= 1'b0;
    end else begin
      full <= i_push | (full & i_idu_freeze);
      vld  <= release_entry;
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      entry <= i_push_entry;
    end
    if (release_entry) begin
      out_inst <= entry.inst;
      out_pc   <= entry.pc;
    end
  end

  assign o_full        = full;
  assign o_ifu_vld     = vld;
  assign o_ifu_inst    = out_inst;
  assign o_ifu_inst_pc = out_pc;

endmodule

// File: source/ifu_fetch_ctrl.sv
`timescale 1ns/1ns

module ifu_fetch_ctrl #(
  parameter ifu_core_pkg::addr_t reset_pc = ifu_core_pkg::default_reset_pc
) (
  input  logic                         clk,
  input  logic                         rst,

  // execute stage
  input  logic                         i_alu_vld,
  input  logic                         i_alu_freeze,
  input  logic                         i_alu_br_miss,
  input  logic                         i_alu_trap,
  input  ifu_core_pkg::addr_t          i_alu_pc_next,

  // instruction bus
  output logic                         o_instbus_req,
  output ifu_core_pkg::addr_t          o_instbus_addr,
  input  logic                         i_instbus_ack,
  input  ifu_core_pkg::inst_t          i_instbus_data,

  // hold buffer
  input  logic                         i_full,
  output logic                         o_push,
  output ifu_fetch_pkg::fetch_entry_t  o_push_entry,
  output logic                         o_flush
);

  // next address to fetch
  ifu_core_pkg::addr_t pc;
  // address of the request on the bus, kept until the next issue
  ifu_core_pkg::addr_t req_addr;
  logic                req;
  logic                outstanding;
  // outstanding response belongs to the old stream
  logic                stale;

  logic                redirect;
  logic                alu_freeze;
  logic                resp_done;
  logic                busy_next;
  logic                issue_redirect;
  logic                issue_seq;
  logic                issue;

  // branch miss or trap from execute
  assign redirect   = i_alu_vld & (i_alu_br_miss | i_alu_trap);
  assign alu_freeze = i_alu_vld & i_alu_freeze & ~redirect;

  assign resp_done = outstanding & i_instbus_ack;
  // still waiting on the bus after this edge
  assign busy_next = outstanding & ~i_instbus_ack;

  // response capture, old-stream words are dropped here
  assign o_push            = resp_done & ~stale;
  assign o_push_entry.inst = i_instbus_data;
  assign o_push_entry.pc   = req_addr;

  assign o_flush = redirect;

  // redirect goes straight to the target when the bus is free
  assign issue_redirect = redirect & ~busy_next;

  // sequential fetch, only with the bus idle and room downstream
  assign issue_seq = ~redirect & ~busy_next & ~o_push & ~i_full & ~alu_freeze;

  assign issue = issue_redirect | issue_seq;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= reset_pc;
      req         <= 1'b0;
      outstanding <= 1'b0;
      stale       <= 1'b0;
    end else begin
      req <= issue;

      if (issue_redirect) begin
        pc <= i_alu_pc_next + ifu_core_pkg::inst_bytes;
      end else if (redirect) begin
        // target is fetched once the stale response is back
        pc <= i_alu_pc_next;
      end else if (issue_seq) begin
        pc <= pc + ifu_core_pkg::inst_bytes;
      end

      if (issue) begin
        outstanding <= 1'b1;
      end else if (resp_done) begin
        outstanding <= 1'b0;
      end

      if (redirect && busy_next) begin
        stale <= 1'b1;
      end else if (resp_done) begin
        stale <= 1'b0;
      end
    end
  end

  // request address
  always_ff @(posedge clk) begin
    if (issue_redirect) begin
      req_addr <= i_alu_pc_next;
    end else if (issue_seq) begin
      req_addr <= pc;
    end
  end

  assign o_instbus_req  = req;
  assign o_instbus_addr = req_addr;

endmodule

// File: source/ifu_fetch_pkg.sv
package ifu_fetch_pkg;

  // fetched word paired with the address it came from
  typedef struct packed {
    ifu_core_pkg::inst_t inst;
    ifu_core_pkg::addr_t pc;
  } fetch_entry_t;

endpackage

// File: source/ifu_core_pkg.sv
package ifu_core_pkg;

  // data and address width
  localparam int unsigned xlen = 32;

  // instruction address
  typedef logic [xlen-1:0] addr_t;

  // raw instruction word
  typedef logic [xlen-1:0] inst_t;

  // pc step, one 32-bit instruction
  localparam addr_t inst_bytes = addr_t'(4);

  // default reset vector
  localparam addr_t default_reset_pc = '0;

endpackage
